//--- Bender.yml
package:
  name: hip_rst

sources:
  - design/hip_rst_pkg.sv
  - design/status_sync.sv
  - design/ltssm_monitor.sv
  - design/serdes_rst_seq.sv
  - design/core_rst_gen.sv
  - design/hip_rst_top.sv
  - target: simulation
    files:
      - bench/hip_rst_tb.sv

//--- bench/hip_rst_tb.sv
// testbench for the PCIe reset controller, drives random stimulus and checks a cycle model each clock
`timescale 1ns/1ps
`default_nettype none

module hip_rst_tb;

   localparam int WS_LONG   = 40;
   localparam int WS_SHORT  = 8;
   localparam int PLL_STAB  = 15;
   localparam int DETQ_STR  = 20;
   localparam int CORE_RST  = 64;
   localparam int EXIT_HOLD = 16;
   localparam int SEL_TXD   = 0;
   localparam int SEL_RXD   = 1;
   localparam int SEL_CRST  = 2;

   logic                            pld_clk;
   logic                            arst;
   logic                            pll_locked;
   logic [hip_rst_pkg::N_LANES-1:0] rx_freqlocked;
   logic                            fifo_err;
   hip_rst_pkg::ltssm_t             ltssm;
   logic                            dlup_exit;
   logic                            hotrst_exit;
   logic                            l2_exit;
   logic                            txdigitalreset;
   logic                            rxanalogreset;
   logic                            rxdigitalreset;
   logic                            crst;
   logic                            srst;

   logic [31:0] lfsr;
   int          cyc;
   int          checks;
   int          errors;

   // model state
   hip_rst_pkg::serdes_status_t    m_sync1;
   hip_rst_pkg::serdes_status_t    m_sync2;
   hip_rst_pkg::serdes_status_t    m_status;
   hip_rst_pkg::ltssm_t            m_l1;
   hip_rst_pkg::ltssm_t            m_l2;
   hip_rst_pkg::serdes_rst_state_e m_state;
   hip_rst_pkg::link_exit_t        m_exits_q;
   int                             m_str_left;
   int                             m_pll_cnt;
   int                             m_lock_left;
   int                             m_timer;
   int                             m_hold;
   logic                           m_req;
   logic                           m_core;
   logic                           m_in_detect;
   logic                           m_disabled;
   logic                           m_stretch;
   logic                           m_held;
   logic                           m_stable;

   hip_rst_top #(
      .WS_LONG_CYCLES        (WS_LONG),
      .WS_SHORT_CYCLES       (WS_SHORT),
      .PLL_STABLE_CYCLES     (PLL_STAB),
      .MASK_RXDRST_IN_DETECT (1'b1),
      .DETQ_STRETCH_CYCLES   (DETQ_STR),
      .CORE_RST_CYCLES       (CORE_RST),
      .EXIT_HOLD_CYCLES      (EXIT_HOLD)
   ) hip_rst_top_i (
      .pld_clk        (pld_clk),
      .arst           (arst),
      .pll_locked     (pll_locked),
      .rx_freqlocked  (rx_freqlocked),
      .fifo_err       (fifo_err),
      .ltssm          (ltssm),
      .dlup_exit      (dlup_exit),
      .hotrst_exit    (hotrst_exit),
      .l2_exit        (l2_exit),
      .txdigitalreset (txdigitalreset),
      .rxanalogreset  (rxanalogreset),
      .rxdigitalreset (rxdigitalreset),
      .crst           (crst),
      .srst           (srst)
   );

   always #10 pld_clk = ~pld_clk;

   always @(posedge pld_clk) cyc <= cyc + 1;

   ////////////////////////////////////////////////////////////////////////////
   // cycle model
   ////////////////////////////////////////////////////////////////////////////

   assign m_in_detect = (m_l1 == hip_rst_pkg::LTSSM_DETQ) || (m_l1 == hip_rst_pkg::LTSSM_DETA);
   assign m_disabled  = (m_l1 == hip_rst_pkg::LTSSM_DIS);
   assign m_stretch   = (m_str_left != 0);
   assign m_held      = m_status.rx_locked || (m_lock_left != 0);
   assign m_stable    = m_status.pll_locked && (m_pll_cnt == PLL_STAB);

   always @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         m_sync1     <= '0;
         m_sync2     <= '0;
         m_status    <= '0;
         m_l1        <= hip_rst_pkg::LTSSM_DETQ;
         m_l2        <= hip_rst_pkg::LTSSM_DETQ;
         m_str_left  <= 0;
         m_pll_cnt   <= 0;
         m_lock_left <= 0;
         m_timer     <= WS_LONG;
         m_state     <= hip_rst_pkg::WAIT_TX_PLL;
         m_exits_q   <= '1;
         m_req       <= 1'b0;
         m_hold      <= 0;
         m_core      <= 1'b1;
      end else begin
         m_sync1  <= {pll_locked, &rx_freqlocked, fifo_err};
         m_sync2  <= m_sync1;
         m_status <= m_sync2;
         m_l1     <= ltssm;
         m_l2     <= m_l1;
         // window opens on Detect.Active falling back to Detect.Quiet
         if (m_l1 == hip_rst_pkg::LTSSM_DETQ && m_l2 == hip_rst_pkg::LTSSM_DETA)
            m_str_left <= DETQ_STR;
         else if (m_str_left > 0)
            m_str_left <= m_str_left - 1;
         if (!m_status.pll_locked)
            m_pll_cnt <= 0;
         else if (m_pll_cnt < PLL_STAB)
            m_pll_cnt <= m_pll_cnt + 1;
         if (m_status.rx_locked)
            m_lock_left <= 7;
         else if (m_lock_left > 0)
            m_lock_left <= m_lock_left - 1;
         case (m_state)
            hip_rst_pkg::WAIT_TX_PLL:
               if (m_stable && m_timer == 0) m_state <= hip_rst_pkg::STABLE_TX_PLL;
            hip_rst_pkg::STABLE_TX_PLL:
               if (m_held) m_state <= hip_rst_pkg::WAIT_RX;
            hip_rst_pkg::WAIT_RX:
               if (!m_held) m_state <= hip_rst_pkg::STABLE_TX_PLL;
               else if (m_timer == 0) m_state <= hip_rst_pkg::RUN;
            default:
               if (!m_held) m_state <= hip_rst_pkg::WAIT_TX_PLL;
               else if (m_status.fifo_err) m_state <= hip_rst_pkg::STABLE_TX_PLL;
         endcase
         if (m_state == hip_rst_pkg::RUN && !m_held)
            m_timer <= WS_LONG;
         else if (m_state == hip_rst_pkg::STABLE_TX_PLL && m_held)
            m_timer <= WS_SHORT;
         else if (m_timer > 0)
            m_timer <= m_timer - 1;
         m_exits_q <= {dlup_exit, hotrst_exit, l2_exit};
         m_req     <= !(&m_exits_q) || m_disabled || m_stretch;
         if (m_req) begin
            m_hold <= CORE_RST - EXIT_HOLD;
            m_core <= 1'b1;
         end else begin
            if (m_hold < CORE_RST) m_hold <= m_hold + 1;
            if (m_hold == CORE_RST) m_core <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic int unsigned take_bits(input int n);
      int unsigned v;
      logic        fb;
      v = 0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = (v << 1) | fb;
      end
      return v;
   endfunction

   function automatic logic out_bit(input int sel);
      case (sel)
         SEL_TXD: return txdigitalreset;
         SEL_RXD: return rxdigitalreset;
         default: return crst;
      endcase
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge pld_clk);
   endtask

   task automatic wait_output(input int sel, input logic val, input int limit, input string what);
      int n;
      n = 0;
      while (out_bit(sel) !== val && n < limit) begin
         @(negedge pld_clk);
         n++;
      end
      if (out_bit(sel) !== val) begin
         errors++;
         $display("ERROR: gave up after %0d cycles waiting for %s", limit, what);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("test %s finished with %0d errors", name, errors - errs_before);
   endtask

   // outputs only move on the rising edge
   always @(negedge pld_clk) begin
      check_bit("txdigitalreset", txdigitalreset, m_state == hip_rst_pkg::WAIT_TX_PLL);
      check_bit("rxanalogreset", rxanalogreset, m_state == hip_rst_pkg::WAIT_TX_PLL);
      check_bit("rxdigitalreset", rxdigitalreset, m_state != hip_rst_pkg::RUN && !m_in_detect);
      check_bit("crst", crst, m_core);
      check_bit("srst", srst, m_core);
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int          e0;
      int          k;
      int          n;
      int          rst_done;
      int          pll_at;
      int          drop;
      int          width;
      int          len;
      int unsigned lane;
      int unsigned kind;
      logic        saw_txd;

      pld_clk       = 1'b0;
      arst          = 1'b1;
      pll_locked    = 1'b0;
      rx_freqlocked = '0;
      fifo_err      = 1'b0;
      ltssm         = hip_rst_pkg::LTSSM_POL;
      dlup_exit     = 1'b1;
      hotrst_exit   = 1'b1;
      l2_exit       = 1'b1;
      lfsr          = 32'ha499618e;
      cyc           = 0;
      checks        = 0;
      errors        = 0;

      // reset state
      e0 = errors;
      @(negedge pld_clk);
      if (txdigitalreset !== 1'b1 || rxanalogreset !== 1'b1 ||
          crst !== 1'b1 || srst !== 1'b1) begin
         errors++;
         $display("ERROR: a reset output is low while arst is asserted");
      end
      idle(3);
      arst     = 1'b0;
      rst_done = cyc;
      idle(2);
      if ({txdigitalreset, rxanalogreset, rxdigitalreset, crst, srst} !== 5'h1f) begin
         errors++;
         $display("ERROR: not all outputs are high right after reset");
      end
      report_test("reset_state", e0);

      // power-up, PLL first and then lanes one by one
      e0 = errors;
      idle(take_bits(4));
      pll_locked = 1'b1;
      pll_at     = cyc;
      for (k = 0; k < hip_rst_pkg::N_LANES; k++) begin
         idle(take_bits(2));
         rx_freqlocked[k] = 1'b1;
      end
      wait_output(SEL_TXD, 1'b0, 200, "txdigitalreset release at power-up");
      if (cyc - rst_done < WS_LONG || cyc - pll_at < PLL_STAB + 3) begin
         errors++;
         $display("ERROR: TX reset released before the long wait or the PLL stability count");
      end
      wait_output(SEL_RXD, 1'b0, 100, "rxdigitalreset release at power-up");
      report_test("power_up", e0);

      // lane drops, short ones ride through the hysteresis
      e0 = errors;
      for (k = 0; k < 6; k++) begin
         drop    = (k % 2 == 0) ? 1 + take_bits(3) : 8 + take_bits(3);
         lane    = take_bits(3);
         saw_txd = 1'b0;
         rx_freqlocked[lane] = 1'b0;
         for (n = 0; n < drop + 15; n++) begin
            @(negedge pld_clk);
            if (n == drop - 1) rx_freqlocked[lane] = 1'b1;
            if (txdigitalreset) saw_txd = 1'b1;
         end
         if (saw_txd != (drop >= 8)) begin
            errors++;
            $display("ERROR: lane drop of %0d cycles gave the wrong restart behavior", drop);
         end
         wait_output(SEL_RXD, 1'b0, 200, "rxdigitalreset release after a lane drop");
      end
      report_test("lock_loss", e0);

      // FIFO error re-sequences only the RX PCS
      e0 = errors;
      fifo_err = 1'b1;
      idle(1);
      fifo_err = 1'b0;
      wait_output(SEL_RXD, 1'b1, 10, "rxdigitalreset after a FIFO error");
      if (txdigitalreset !== 1'b0 || rxanalogreset !== 1'b0) begin
         errors++;
         $display("ERROR: FIFO error also asserted the TX or analog reset");
      end
      wait_output(SEL_RXD, 1'b0, 40, "rxdigitalreset release after a FIFO error");
      report_test("fifo_error", e0);

      // exit strobes and Disable
      e0 = errors;
      wait_output(SEL_CRST, 1'b0, 200, "core reset release after power-up");
      for (k = 0; k < 8; k++) begin
         kind  = take_bits(2);
         width = 1 + take_bits(2);
         case (kind)
            0: dlup_exit = 1'b0;
            1: hotrst_exit = 1'b0;
            2: l2_exit = 1'b0;
            default: ltssm = hip_rst_pkg::LTSSM_DIS;
         endcase
         len = 0;
         for (n = 0; n < width + EXIT_HOLD + 12; n++) begin
            @(negedge pld_clk);
            if (n == width - 1) begin
               dlup_exit   = 1'b1;
               hotrst_exit = 1'b1;
               l2_exit     = 1'b1;
               ltssm       = hip_rst_pkg::LTSSM_POL;
            end
            if (crst) len++;
         end
         if (len != width + EXIT_HOLD) begin
            errors++;
            $display("MISMATCH crst_high_cycles: got %h expected %h", len, width + EXIT_HOLD);
         end
         wait_output(SEL_CRST, 1'b0, 4, "core reset release after an exit");
         idle(take_bits(3));
      end
      report_test("core_exits", e0);

      // Detect masking and the Detect.Quiet stretch
      e0 = errors;
      ltssm = hip_rst_pkg::LTSSM_DETA;
      idle(2);
      fifo_err = 1'b1;
      idle(1);
      fifo_err = 1'b0;
      for (n = 0; n < 12; n++) begin
         @(negedge pld_clk);
         if (rxdigitalreset !== 1'b0) begin
            errors++;
            $display("MISMATCH rxdigitalreset: got %h expected %h", rxdigitalreset, 1'b0);
         end
      end
      ltssm = hip_rst_pkg::LTSSM_DETQ;
      len   = 0;
      for (n = 0; n < DETQ_STR + EXIT_HOLD + 12; n++) begin
         @(negedge pld_clk);
         if (crst) len++;
      end
      if (len != DETQ_STR + EXIT_HOLD) begin
         errors++;
         $display("MISMATCH crst_high_cycles: got %h expected %h", len, DETQ_STR + EXIT_HOLD);
      end
      wait_output(SEL_CRST, 1'b0, 4, "core reset release after the Detect.Quiet stretch");
      ltssm = hip_rst_pkg::LTSSM_POL;
      idle(4);
      report_test("detect", e0);

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/core_rst_gen.sv
// holds the PCIe core in reset after an enabled link exit and releases it after the hold count
`timescale 1ns/1ps
`default_nettype none

module core_rst_gen #(
   parameter int unsigned CORE_RST_CYCLES   = 1024,
   parameter int unsigned EXIT_HOLD_CYCLES  = 16,
   parameter bit          USE_DLUP_EXIT     = 1'b1,
   parameter bit          USE_HOTRESET      = 1'b1,
   parameter bit          USE_L2            = 1'b1,
   parameter bit          USE_LTSSM_DISABLE = 1'b1,
   parameter bit          USE_DETQ_EXIT     = 1'b1
) (
   input  logic                        pld_clk,
   input  logic                        arst,
   input  hip_rst_pkg::link_exit_t     exits,
   input  hip_rst_pkg::ltssm_events_t  events,
   output logic                        core_rst
);

   localparam int CW = $clog2(CORE_RST_CYCLES + 1);

   hip_rst_pkg::link_exit_t exits_q;
   logic                    req_d;
   logic                    req_q;
   logic [CW-1:0]           hold_cnt;

   // strobes are active low, so the inactive value is all ones
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         exits_q <= '1;
         req_q   <= 1'b0;
      end else begin
         exits_q <= exits;
         req_q   <= req_d;
      end
   end

   assign req_d = (USE_DLUP_EXIT     & ~exits_q.dlup_exit)   |
                  (USE_HOTRESET      & ~exits_q.hotrst_exit) |
                  (USE_L2            & ~exits_q.l2_exit)     |
                  (USE_LTSSM_DISABLE & events.disabled)      |
                  (USE_DETQ_EXIT     & events.detq_stretch);

   ////////////////////////////////////////////////////////////////////////////
   // hold counter and core reset
   ////////////////////////////////////////////////////////////////////////////

   // a request leaves only the hold part of the full count to run
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         hold_cnt <= '0;
      end else if (req_q) begin
         hold_cnt <= CW'(CORE_RST_CYCLES - EXIT_HOLD_CYCLES);
      end else if (hold_cnt != CW'(CORE_RST_CYCLES)) begin
         hold_cnt <= hold_cnt + CW'(1);
      end
   end

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         core_rst <= 1'b1;
      end else if (req_q) begin
         core_rst <= 1'b1;
      end else if (hold_cnt == CW'(CORE_RST_CYCLES)) begin
         core_rst <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   // every exit condition reaches the core reset through the request flop
   a_req_sets_core_rst : assert property (
      @(posedge pld_clk) disable iff (arst)
      req_d |-> ##2 core_rst
   ) else $error("core reset not asserted after exit request");

endmodule

`default_nettype wire

//--- design/hip_rst_pkg.sv
// shared types and LTSSM encodings, referenced by scoped name from every reset controller block
`default_nettype none

package hip_rst_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes and LTSSM codes
   ////////////////////////////////////////////////////////////////////////////

   // receive lanes on the hard IP
   localparam int N_LANES = 8;

   typedef logic [4:0] ltssm_t;

   // only the states the controller cares about
   localparam ltssm_t LTSSM_DETQ = 5'h00;
   localparam ltssm_t LTSSM_DETA = 5'h01;
   localparam ltssm_t LTSSM_POL  = 5'h02;
   localparam ltssm_t LTSSM_DIS  = 5'h10;

   ////////////////////////////////////////////////////////////////////////////
   // grouped signals between the blocks
   ////////////////////////////////////////////////////////////////////////////

   // transceiver status after synchronization
   typedef struct packed {
      logic pll_locked;
      logic rx_locked;
      logic fifo_err;
   } serdes_status_t;

   // decoded LTSSM conditions
   typedef struct packed {
      logic in_detect;
      logic disabled;
      logic detq_stretch;
   } ltssm_events_t;

   // exit strobes from the hard IP, all active low
   typedef struct packed {
      logic dlup_exit;
      logic hotrst_exit;
      logic l2_exit;
   } link_exit_t;

   // resets to the transceiver, active high
   typedef struct packed {
      logic txdigital;
      logic rxanalog;
      logic rxdigital;
   } serdes_rst_t;

   typedef enum logic [1:0] {
      WAIT_TX_PLL,
      STABLE_TX_PLL,
      WAIT_RX,
      RUN
   } serdes_rst_state_e;

endpackage

`default_nettype wire

//--- design/hip_rst_top.sv
// top of the PCIe hard IP reset controller, connects the blocks and maps the grouped signals to pins
`timescale 1ns/1ps
`default_nettype none

module hip_rst_top #(
   parameter int unsigned WS_LONG_CYCLES        = 250000,
   parameter int unsigned WS_SHORT_CYCLES       = 32,
   parameter int unsigned PLL_STABLE_CYCLES     = 127,
   parameter bit          MASK_RXDRST_IN_DETECT = 1'b1,
   parameter int unsigned DETQ_STRETCH_CYCLES   = 256,
   parameter int unsigned CORE_RST_CYCLES       = 1024,
   parameter int unsigned EXIT_HOLD_CYCLES      = 16,
   parameter bit          USE_DLUP_EXIT         = 1'b1,
   parameter bit          USE_HOTRESET          = 1'b1,
   parameter bit          USE_L2                = 1'b1,
   parameter bit          USE_LTSSM_DISABLE     = 1'b1,
   parameter bit          USE_DETQ_EXIT         = 1'b1
) (
   input  logic                            pld_clk,
   input  logic                            arst,
   input  logic                            pll_locked,
   input  logic [hip_rst_pkg::N_LANES-1:0] rx_freqlocked,
   input  logic                            fifo_err,
   input  hip_rst_pkg::ltssm_t             ltssm,
   input  logic                            dlup_exit,
   input  logic                            hotrst_exit,
   input  logic                            l2_exit,
   output logic                            txdigitalreset,
   output logic                            rxanalogreset,
   output logic                            rxdigitalreset,
   output logic                            crst,
   output logic                            srst
);

   hip_rst_pkg::serdes_status_t status;
   hip_rst_pkg::ltssm_events_t  events;
   hip_rst_pkg::link_exit_t     exits;
   hip_rst_pkg::serdes_rst_t    serdes_rst;
   logic                        core_rst;

   assign exits.dlup_exit   = dlup_exit;
   assign exits.hotrst_exit = hotrst_exit;
   assign exits.l2_exit     = l2_exit;

   status_sync status_sync_i (
      .pld_clk       (pld_clk),
      .arst          (arst),
      .pll_locked    (pll_locked),
      .rx_freqlocked (rx_freqlocked),
      .fifo_err      (fifo_err),
      .status        (status)
   );

   ltssm_monitor #(
      .DETQ_STRETCH_CYCLES (DETQ_STRETCH_CYCLES)
   ) ltssm_monitor_i (
      .pld_clk (pld_clk),
      .arst    (arst),
      .ltssm   (ltssm),
      .events  (events)
   );

   serdes_rst_seq #(
      .WS_LONG_CYCLES        (WS_LONG_CYCLES),
      .WS_SHORT_CYCLES       (WS_SHORT_CYCLES),
      .PLL_STABLE_CYCLES     (PLL_STABLE_CYCLES),
      .MASK_RXDRST_IN_DETECT (MASK_RXDRST_IN_DETECT)
   ) serdes_rst_seq_i (
      .pld_clk (pld_clk),
      .arst    (arst),
      .status  (status),
      .events  (events),
      .rst     (serdes_rst)
   );

   core_rst_gen #(
      .CORE_RST_CYCLES   (CORE_RST_CYCLES),
      .EXIT_HOLD_CYCLES  (EXIT_HOLD_CYCLES),
      .USE_DLUP_EXIT     (USE_DLUP_EXIT),
      .USE_HOTRESET      (USE_HOTRESET),
      .USE_L2            (USE_L2),
      .USE_LTSSM_DISABLE (USE_LTSSM_DISABLE),
      .USE_DETQ_EXIT     (USE_DETQ_EXIT)
   ) core_rst_gen_i (
      .pld_clk  (pld_clk),
      .arst     (arst),
      .exits    (exits),
      .events   (events),
      .core_rst (core_rst)
   );

   assign txdigitalreset = serdes_rst.txdigital;
   assign rxanalogreset  = serdes_rst.rxanalog;
   assign rxdigitalreset = serdes_rst.rxdigital;

   // config and sticky resets share one source
   assign crst = core_rst;
   assign srst = core_rst;

endmodule

`default_nettype wire

//--- design/ltssm_monitor.sv
// pipelines the LTSSM state, decodes Detect and Disable and stretches a Detect.Active to Detect.Quiet exit
`timescale 1ns/1ps
`default_nettype none

module ltssm_monitor #(
   parameter int unsigned DETQ_STRETCH_CYCLES = 256
) (
   input  logic                        pld_clk,
   input  logic                        arst,
   input  hip_rst_pkg::ltssm_t         ltssm,
   output hip_rst_pkg::ltssm_events_t  events
);

   localparam int CW = $clog2(DETQ_STRETCH_CYCLES + 1);

   hip_rst_pkg::ltssm_t ltssm_r;
   hip_rst_pkg::ltssm_t ltssm_rr;
   logic                detq_edge;
   logic [CW-1:0]       stretch_cnt;
   logic                stretch_q;

   ////////////////////////////////////////////////////////////////////////////
   // state pipeline
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         ltssm_r  <= hip_rst_pkg::LTSSM_DETQ;
         ltssm_rr <= hip_rst_pkg::LTSSM_DETQ;
      end else begin
         ltssm_r  <= ltssm;
         ltssm_rr <= ltssm_r;
      end
   end

   // link fell back from Detect.Active to Detect.Quiet
   assign detq_edge = (ltssm_r == hip_rst_pkg::LTSSM_DETQ) &&
                      (ltssm_rr == hip_rst_pkg::LTSSM_DETA);

   ////////////////////////////////////////////////////////////////////////////
   // stretch window, about 1 us of core reset
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         stretch_cnt <= '0;
         stretch_q   <= 1'b0;
      end else if (detq_edge) begin
         // a new edge restarts the window
         stretch_cnt <= CW'(DETQ_STRETCH_CYCLES - 1);
         stretch_q   <= 1'b1;
      end else if (stretch_cnt != '0) begin
         stretch_cnt <= stretch_cnt - CW'(1);
      end else begin
         stretch_q   <= 1'b0;
      end
   end

   assign events.in_detect    = (ltssm_r == hip_rst_pkg::LTSSM_DETQ) ||
                                (ltssm_r == hip_rst_pkg::LTSSM_DETA);
   assign events.disabled     = (ltssm_r == hip_rst_pkg::LTSSM_DIS);
   assign events.detq_stretch = stretch_q;

endmodule

`default_nettype wire

//--- design/serdes_rst_seq.sv
// sequences the transceiver TX and RX resets from PLL and lane lock, with recovery on lock loss or FIFO error
`timescale 1ns/1ps
`default_nettype none

module serdes_rst_seq #(
   parameter int unsigned WS_LONG_CYCLES        = 250000,
   parameter int unsigned WS_SHORT_CYCLES       = 32,
   parameter int unsigned PLL_STABLE_CYCLES     = 127,
   parameter bit          MASK_RXDRST_IN_DETECT = 1'b1
) (
   input  logic                        pld_clk,
   input  logic                        arst,
   input  hip_rst_pkg::serdes_status_t status,
   input  hip_rst_pkg::ltssm_events_t  events,
   output hip_rst_pkg::serdes_rst_t    rst
);

   localparam int TW = $clog2(WS_LONG_CYCLES + 1);
   localparam int PW = $clog2(PLL_STABLE_CYCLES + 1);

   hip_rst_pkg::serdes_rst_state_e state_q;
   hip_rst_pkg::serdes_rst_state_e state_d;
   hip_rst_pkg::serdes_rst_t       rst_q;
   hip_rst_pkg::serdes_rst_t       rst_d;
   logic [TW-1:0]                  timer_q;
   logic                           timer_zero;
   logic                           ld_long;
   logic                           ld_short;
   logic [PW-1:0]                  pll_cnt;
   logic                           pll_stable;
   logic [2:0]                     lock_cnt;
   logic                           lock_held;

   ////////////////////////////////////////////////////////////////////////////
   // lock qualification
   ////////////////////////////////////////////////////////////////////////////

   // PLL must stay locked for a full count before TX leaves reset
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         pll_cnt <= '0;
      end else if (!status.pll_locked) begin
         pll_cnt <= '0;
      end else if (pll_cnt != PW'(PLL_STABLE_CYCLES)) begin
         pll_cnt <= pll_cnt + PW'(1);
      end
   end

   assign pll_stable = (pll_cnt == PW'(PLL_STABLE_CYCLES));

   // hysteresis so short lane drops do not restart the sequence
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         lock_cnt <= 3'd0;
      end else if (status.rx_locked) begin
         lock_cnt <= 3'd7;
      end else if (lock_cnt != 3'd0) begin
         lock_cnt <= lock_cnt - 3'd1;
      end
   end

   assign lock_held = status.rx_locked || (lock_cnt != 3'd0);

   ////////////////////////////////////////////////////////////////////////////
   // wait timer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         timer_q <= TW'(WS_LONG_CYCLES);
      end else if (ld_long) begin
         timer_q <= TW'(WS_LONG_CYCLES);
      end else if (ld_short) begin
         timer_q <= TW'(WS_SHORT_CYCLES);
      end else if (!timer_zero) begin
         timer_q <= timer_q - TW'(1);
      end
   end

   assign timer_zero = (timer_q == '0);

   ////////////////////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d  = state_q;
      ld_long  = 1'b0;
      ld_short = 1'b0;
      case (state_q)
         hip_rst_pkg::WAIT_TX_PLL: begin
            if (status.pll_locked && pll_stable && timer_zero) begin
               state_d = hip_rst_pkg::STABLE_TX_PLL;
            end
         end
         hip_rst_pkg::STABLE_TX_PLL: begin
            if (lock_held) begin
               state_d  = hip_rst_pkg::WAIT_RX;
               ld_short = 1'b1;
            end
         end
         hip_rst_pkg::WAIT_RX: begin
            if (!lock_held) begin
               state_d = hip_rst_pkg::STABLE_TX_PLL;
            end else if (timer_zero) begin
               state_d = hip_rst_pkg::RUN;
            end
         end
         hip_rst_pkg::RUN: begin
            // lock loss wins over a FIFO error
            if (!lock_held) begin
               state_d = hip_rst_pkg::WAIT_TX_PLL;
               ld_long = 1'b1;
            end else if (status.fifo_err) begin
               state_d = hip_rst_pkg::STABLE_TX_PLL;
            end
         end
      endcase
   end

   // resets follow the next state so they change on the transition edge
   always_comb begin
      case (state_d)
         hip_rst_pkg::WAIT_TX_PLL: rst_d = 3'b111;
         hip_rst_pkg::RUN:         rst_d = 3'b000;
         default:                  rst_d = 3'b001;
      endcase
   end

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         state_q <= hip_rst_pkg::WAIT_TX_PLL;
         rst_q   <= '1;
      end else begin
         state_q <= state_d;
         rst_q   <= rst_d;
      end
   end

   assign rst.txdigital = rst_q.txdigital;
   assign rst.rxanalog  = rst_q.rxanalog;
   // receiver PCS runs free during Detect when masking is on
   assign rst.rxdigital = rst_q.rxdigital & ~(MASK_RXDRST_IN_DETECT & events.in_detect);

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   // RX PCS comes out of reset only after TX has been out for a while
   a_rxd_after_txd : assert property (
      @(posedge pld_clk) disable iff (arst)
      $fell(rst_q.rxdigital) |-> !rst_q.txdigital && $past(!rst_q.txdigital)
   ) else $error("rxdigitalreset released while txdigitalreset asserted");

endmodule

`default_nettype wire

//--- design/status_sync.sv
// brings the transceiver lock and FIFO error status into pld_clk through 3-flop synchronizers
`timescale 1ns/1ps
`default_nettype none

module status_sync (
   input  logic                              pld_clk,
   input  logic                              arst,
   input  logic                              pll_locked,
   input  logic [hip_rst_pkg::N_LANES-1:0]   rx_freqlocked,
   input  logic                              fifo_err,
   output hip_rst_pkg::serdes_status_t       status
);

   // raw status, lanes reduced before the first flop
   hip_rst_pkg::serdes_status_t        status_raw;
   // stage 0 takes the pins, stage 2 is the output
   hip_rst_pkg::serdes_status_t [2:0]  sync_q;

   // receive side counts as locked only when every lane is
   assign status_raw.pll_locked = pll_locked;
   assign status_raw.rx_locked  = &rx_freqlocked;
   assign status_raw.fifo_err   = fifo_err;

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[1:0], status_raw};
      end
   end

   assign status = sync_q[2];

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   // the lanes lock on the TX PLL reference, so RX lock follows PLL lock
   a_rx_lock_needs_pll : assert property (
      @(posedge pld_clk) disable iff (arst)
      $rose(status.rx_locked) |-> status.pll_locked
   ) else $error("rx_locked rose while pll_locked was low");

endmodule

`default_nettype wire

//--- src.f
design/hip_rst_pkg.sv
design/status_sync.sv
design/ltssm_monitor.sv
design/serdes_rst_seq.sv
design/core_rst_gen.sv
design/hip_rst_top.sv
bench/hip_rst_tb.sv
